// File: all.f
logic/exceptPkg.sv
logic/cp0Regs.sv
logic/cp0Bypass.sv
logic/exceptCollect.sv
logic/exceptResolve.sv
logic/exceptTop.sv
sim/exceptTb.sv

// File: Bender.yml
package:
  name: except_mem

sources:
  - logic/exceptPkg.sv
  - logic/cp0Regs.sv
  - logic/cp0Bypass.sv
  - logic/exceptCollect.sv
  - logic/exceptResolve.sv
  - logic/exceptTop.sv
  - target: simulation
    files:
      - sim/exceptTb.sv

// File: sim/exceptTb.sv
`timescale 1ns/1ps

module exceptTb;

    logic                    clk;
    logic                    rstN;
    logic                    instValid;
    logic [31:0]             pcIn;
    logic [31:0]             memAddr;
    exceptPkg::exceptFlags_t pipeFlags;
    exceptPkg::regsWrType_t  memWrTypeIn;
    exceptPkg::cp0Write_t    wbCp0Wr;
    logic [5:0]              hwInt;
    logic [4:0]              cp0RdAddr;
    exceptPkg::regsWrType_t  memWrTypeOut;
    logic                    flush;
    exceptPkg::npcSel_e      npcSel;
    logic [31:0]             redirectPc;
    exceptPkg::exceptFlags_t excFlags;
    logic [31:0]             cp0RdData;

    int valueErrs;
    int timeoutErrs;
    int seed;

    exceptTop exceptTop_inst (
        .clk_i        (clk),
        .rstN_i       (rstN),
        .instValid_i  (instValid),
        .pc_i         (pcIn),
        .memAddr_i    (memAddr),
        .pipeFlags_i  (pipeFlags),
        .memWrType_i  (memWrTypeIn),
        .wbCp0Wr_i    (wbCp0Wr),
        .hwInt_i      (hwInt),
        .cp0RdAddr_i  (cp0RdAddr),
        .memWrType_o  (memWrTypeOut),
        .flush_o      (flush),
        .npcSel_o     (npcSel),
        .redirectPc_o (redirectPc),
        .excFlags_o   (excFlags),
        .cp0RdData_o  (cp0RdData)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // **************************************************
    // compare tasks
    // **************************************************
    task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("FAILED %s: expected %08h, got %08h", name, exp, act);
            valueErrs++;
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s: expected %01h, got %01h", name, exp, act);
            valueErrs++;
        end
    endtask

    task automatic checkWrType(input string name, input exceptPkg::regsWrType_t exp,
                               input exceptPkg::regsWrType_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %01h, got %01h", name, exp, act);
            valueErrs++;
        end
    endtask

    task automatic checkNpcSel(input string name, input exceptPkg::npcSel_e exp,
                               input exceptPkg::npcSel_e act);
        if (act !== exp) begin
            $display("FAILED %s: expected %01h, got %01h", name, exp, act);
            valueErrs++;
        end
    endtask

    task automatic checkFlags(input string name, input exceptPkg::exceptFlags_t exp,
                              input exceptPkg::exceptFlags_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %03h, got %03h", name, exp, act);
            valueErrs++;
        end
    endtask

    // **************************************************
    // reference model
    // **************************************************
    // msb of the flag vector ranks first
    function automatic exceptPkg::exceptFlags_t expectWinner(
        input logic                    valid,
        input logic [31:0]             pc,
        input exceptPkg::exceptFlags_t raw,
        input logic                    intOn
    );
        exceptPkg::exceptFlags_t req;
        logic [8:0]              win;
        logic                    found;
        int                      k;
        req              = raw;
        req.interrupt    = intOn;
        req.fetchAddrErr = (pc[1:0] != 2'b00);
        win              = '0;
        found            = 1'b0;
        // bubble raises nothing
        if (valid) begin
            for (k = 8; k >= 0; k--) begin
                if (req[k] && !found) begin
                    win[k] = 1'b1;
                    found  = 1'b1;
                end
            end
        end
        expectWinner = win;
    endfunction

    // ExcCode table for a one-hot winner
    function automatic logic [4:0] codeFor(input exceptPkg::exceptFlags_t win);
        case (1'b1)
            win.interrupt:     codeFor = exceptPkg::EXC_INT;
            win.fetchAddrErr:  codeFor = exceptPkg::EXC_ADEL;
            win.reservedInstr: codeFor = exceptPkg::EXC_RI;
            win.syscall:       codeFor = exceptPkg::EXC_SYS;
            win.breakpoint:    codeFor = exceptPkg::EXC_BP;
            win.overflow:      codeFor = exceptPkg::EXC_OV;
            win.storeAddrErr:  codeFor = exceptPkg::EXC_ADES;
            win.loadAddrErr:   codeFor = exceptPkg::EXC_ADEL;
            default:           codeFor = 5'd0;
        endcase
    endfunction

    // **************************************************
    // drive and sample helpers
    // **************************************************
    // one mem-stage cycle with outputs read at the falling edge
    task automatic driveInst(
        input logic                    valid,
        input logic [31:0]             pc,
        input logic [31:0]             addr,
        input exceptPkg::exceptFlags_t fl,
        input exceptPkg::cp0Write_t    wb
    );
        @(posedge clk);
        instValid   <= valid;
        pcIn        <= pc;
        memAddr     <= addr;
        pipeFlags   <= fl;
        memWrTypeIn <= $random(seed);
        wbCp0Wr     <= wb;
        @(negedge clk);
    endtask

    // bubble cycle with the mfc0 port pointed at addr
    task automatic readCp0(input logic [4:0] addr, output logic [31:0] data);
        @(posedge clk);
        instValid <= 1'b0;
        pipeFlags <= '0;
        wbCp0Wr   <= '0;
        cp0RdAddr <= addr;
        @(negedge clk);
        data = cp0RdData;
    endtask

    // mtc0 in writeback that lands at the next edge
    task automatic writeCp0(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        instValid <= 1'b0;
        pipeFlags <= '0;
        wbCp0Wr   <= {1'b1, addr, data};
        @(negedge clk);
    endtask

    // same-cycle response for an expected winner
    task automatic compareOutputs(input exceptPkg::exceptFlags_t win,
                                  input logic [31:0] expRedirect);
        exceptPkg::npcSel_e     expSel;
        exceptPkg::regsWrType_t expWt;
        expSel = exceptPkg::NPC_NONE;
        expWt  = memWrTypeIn;
        if (|win) begin
            expSel = win.eret ? exceptPkg::NPC_ERET : exceptPkg::NPC_TRAP;
            expWt  = '0;
        end
        checkFlags("excFlags_o", win, excFlags);
        checkBit("flush_o", |win, flush);
        checkNpcSel("npcSel_o", expSel, npcSel);
        checkWrType("memWrType_o", expWt, memWrTypeOut);
        if (|win) begin
            checkWord("redirectPc_o", expRedirect, redirectPc);
        end
    endtask

    // poll for the flush level with inputs held
    task automatic waitFlush(input int maxCycles, output int cycles);
        cycles = 0;
        while (flush !== 1'b1 && cycles < maxCycles) begin
            @(posedge clk);
            @(negedge clk);
            cycles++;
        end
        if (flush !== 1'b1) begin
            $display("timeout: no flush within %0d cycles of the interrupt request", maxCycles);
            timeoutErrs++;
        end
    endtask

    // **************************************************
    // directed tests
    // **************************************************
    task automatic resetState();
        logic [31:0] rd;
        readCp0(exceptPkg::CP0_STATUS, rd);
        checkWord("Status", exceptPkg::STATUS_RESET, rd);
        compareOutputs('0, 32'd0);
        readCp0(exceptPkg::CP0_CAUSE, rd);
        checkWord("Cause", 32'd0, rd);
        readCp0(exceptPkg::CP0_EPC, rd);
        checkWord("EPC", 32'd0, rd);
        // valid aligned instruction while IE is still clear
        driveInst(1'b1, 32'h0000_0100, 32'd0, '0, '0);
        compareOutputs('0, 32'd0);
    endtask

    task automatic singleTraps();
        exceptPkg::exceptFlags_t fl;
        exceptPkg::exceptFlags_t win;
        logic [31:0]             pc;
        logic [31:0]             addr;
        logic [31:0]             rd;
        int                      i;
        for (i = 0; i < 7; i++) begin
            fl   = '0;
            pc   = $random(seed) & 32'hFFFF_FFFC;
            addr = $random(seed);
            case (i)
                0:       pc = pc | 32'd2;
                1:       fl.reservedInstr = 1'b1;
                2:       fl.syscall = 1'b1;
                3:       fl.breakpoint = 1'b1;
                4:       fl.overflow = 1'b1;
                5:       fl.storeAddrErr = 1'b1;
                default: fl.loadAddrErr = 1'b1;
            endcase
            win = expectWinner(1'b1, pc, fl, 1'b0);
            driveInst(1'b1, pc, addr, fl, '0);
            compareOutputs(win, exceptPkg::TRAP_VECTOR);
            // commit shows one cycle later
            readCp0(exceptPkg::CP0_EPC, rd);
            checkWord("EPC", pc, rd);
            readCp0(exceptPkg::CP0_CAUSE, rd);
            checkWord("Cause.ExcCode", {27'd0, codeFor(win)}, {27'd0, rd[6:2]});
            readCp0(exceptPkg::CP0_STATUS, rd);
            checkBit("Status.EXL", 1'b1, rd[exceptPkg::STATUS_EXL]);
            if (win.fetchAddrErr || win.storeAddrErr || win.loadAddrErr) begin
                readCp0(exceptPkg::CP0_BADVADDR, rd);
                checkWord("BadVAddr", win.fetchAddrErr ? pc : addr, rd);
            end
        end
    endtask

    task automatic priorityOrder();
        exceptPkg::exceptFlags_t raw;
        exceptPkg::exceptFlags_t win;
        logic                    valid;
        logic [31:0]             pc;
        logic [31:0]             addr;
        logic [31:0]             rd;
        logic [31:0]             epcNow;
        int                      n;
        readCp0(exceptPkg::CP0_EPC, epcNow);
        for (n = 0; n < 24; n++) begin
            // sparse flags with about one bit in eight
            raw   = $random(seed) & $random(seed) & $random(seed);
            valid = (($random(seed) & 3) != 0);
            pc    = $random(seed) & 32'hFFFF_FFFC;
            addr  = $random(seed);
            if (($random(seed) & 7) == 0) begin
                pc = pc | 32'd1;
            end
            // lone eret and then a stalled slot full of flags
            if (n == 0) begin
                raw      = '0;
                raw.eret = 1'b1;
                valid    = 1'b1;
            end else if (n == 1) begin
                raw   = '1;
                valid = 1'b0;
            end
            win = expectWinner(valid, pc, raw, 1'b0);
            driveInst(valid, pc, addr, raw, '0);
            compareOutputs(win, win.eret ? epcNow : exceptPkg::TRAP_VECTOR);
            if (|win && !win.eret) begin
                epcNow = pc;
                readCp0(exceptPkg::CP0_CAUSE, rd);
                checkWord("Cause.ExcCode", {27'd0, codeFor(win)}, {27'd0, rd[6:2]});
            end else if (win.eret) begin
                readCp0(exceptPkg::CP0_STATUS, rd);
                checkBit("Status.EXL", 1'b0, rd[exceptPkg::STATUS_EXL]);
            end
        end
    endtask

    task automatic writebackBypass();
        exceptPkg::exceptFlags_t fl;
        logic [31:0]             newEpc;
        logic [31:0]             oldCause;
        logic [31:0]             data;
        logic [31:0]             rd;
        // syscall first so EXL is set
        fl         = '0;
        fl.syscall = 1'b1;
        driveInst(1'b1, 32'h0000_1000, 32'd0, fl, '0);
        // eret meets an EPC write from writeback
        newEpc  = $random(seed) & 32'hFFFF_FFFC;
        fl      = '0;
        fl.eret = 1'b1;
        driveInst(1'b1, 32'h0000_2000, 32'd0, fl, {1'b1, exceptPkg::CP0_EPC, newEpc});
        compareOutputs(fl, newEpc);
        readCp0(exceptPkg::CP0_STATUS, rd);
        checkBit("Status.EXL", 1'b0, rd[exceptPkg::STATUS_EXL]);
        readCp0(exceptPkg::CP0_EPC, rd);
        checkWord("EPC", newEpc, rd);
        // Cause takes the write only under the mask
        readCp0(exceptPkg::CP0_CAUSE, oldCause);
        data = $random(seed);
        writeCp0(exceptPkg::CP0_CAUSE, data);
        readCp0(exceptPkg::CP0_CAUSE, rd);
        checkWord("Cause", (oldCause & ~exceptPkg::CAUSE_WR_MASK)
                         | (data & exceptPkg::CAUSE_WR_MASK), rd);
        // sw bits back to zero
        writeCp0(exceptPkg::CP0_CAUSE, 32'd0);
    endtask

    task automatic interrupts();
        exceptPkg::exceptFlags_t intWin;
        exceptPkg::exceptFlags_t fl;
        logic [31:0]             pc;
        logic [31:0]             rd;
        int                      cycles;
        intWin           = '0;
        intWin.interrupt = 1'b1;
        pc               = 32'h0000_3000;
        // IM all ones with IE on and EXL off
        writeCp0(exceptPkg::CP0_STATUS, 32'h0040_FF01);
        @(posedge clk);
        hwInt     <= 6'b000100;
        instValid <= 1'b1;
        pcIn      <= pc;
        pipeFlags <= '0;
        wbCp0Wr   <= '0;
        @(negedge clk);
        // line not sampled into Cause yet
        checkBit("flush_o", 1'b0, flush);
        waitFlush(4, cycles);
        checkWord("interrupt latency", 32'd1, cycles);
        compareOutputs(intWin, exceptPkg::TRAP_VECTOR);
        readCp0(exceptPkg::CP0_CAUSE, rd);
        checkWord("Cause.ExcCode", {27'd0, exceptPkg::EXC_INT}, {27'd0, rd[6:2]});
        readCp0(exceptPkg::CP0_STATUS, rd);
        checkBit("Status.EXL", 1'b1, rd[exceptPkg::STATUS_EXL]);
        // line still high but EXL holds it off
        driveInst(1'b1, pc + 32'd4, 32'd0, '0, '0);
        compareOutputs('0, 32'd0);
        // drop the line and eret back to pc
        @(posedge clk);
        hwInt     <= '0;
        instValid <= 1'b0;
        @(negedge clk);
        fl      = '0;
        fl.eret = 1'b1;
        driveInst(1'b1, pc + 32'd8, 32'd0, fl, '0);
        compareOutputs(fl, pc);
        // sw interrupt via Cause IP[0]
        writeCp0(exceptPkg::CP0_CAUSE, 32'h0000_0100);
        // stalled slot takes nothing
        readCp0(exceptPkg::CP0_CAUSE, rd);
        checkBit("Cause.IP0", 1'b1, rd[exceptPkg::CAUSE_IP_LO]);
        compareOutputs('0, 32'd0);
        // interrupt outranks an overflow in the same slot
        fl          = '0;
        fl.overflow = 1'b1;
        intWin      = expectWinner(1'b1, pc + 32'd12, fl, 1'b1);
        driveInst(1'b1, pc + 32'd12, 32'd0, fl, '0);
        compareOutputs(intWin, exceptPkg::TRAP_VECTOR);
        readCp0(exceptPkg::CP0_EPC, rd);
        checkWord("EPC", pc + 32'd12, rd);
        // still pending but blocked again by EXL
        driveInst(1'b1, pc + 32'd16, 32'd0, '0, '0);
        compareOutputs('0, 32'd0);
    endtask

    // **************************************************
    // main sequence
    // **************************************************
    initial begin
        int i;
        seed        = 97265;
        valueErrs   = 0;
        timeoutErrs = 0;
        rstN        <= 1'b0;
        instValid   <= 1'b0;
        pcIn        <= '0;
        memAddr     <= '0;
        pipeFlags   <= '0;
        memWrTypeIn <= '0;
        wbCp0Wr     <= '0;
        hwInt       <= '0;
        cp0RdAddr   <= '0;
        for (i = 0; i < 16; i++) begin
            @(posedge clk);
        end
        rstN <= 1'b1;

        resetState();
        singleTraps();
        priorityOrder();
        writebackBypass();
        interrupts();

        $display("value errors: %0d, timeout errors: %0d", valueErrs, timeoutErrs);
        if (valueErrs == 0 && timeoutErrs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // overall bound on the run
    initial begin
        int w;
        for (w = 0; w < 2000; w++) begin
            @(posedge clk);
        end
        $display("watchdog: run did not complete within 2000 cycles");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: logic/exceptTop.sv
`timescale 1ns/1ps

module exceptTop (
    input  logic                    clk_i,
    input  logic                    rstN_i,
    input  logic                    instValid_i,
    input  logic [31:0]             pc_i,
    input  logic [31:0]             memAddr_i,
    input  exceptPkg::exceptFlags_t pipeFlags_i,
    input  exceptPkg::regsWrType_t  memWrType_i,
    input  exceptPkg::cp0Write_t    wbCp0Wr_i,
    input  logic [5:0]              hwInt_i,
    input  logic [4:0]              cp0RdAddr_i,
    output exceptPkg::regsWrType_t  memWrType_o,
    output logic                    flush_o,
    output exceptPkg::npcSel_e      npcSel_o,
    output logic [31:0]             redirectPc_o,
    output exceptPkg::exceptFlags_t excFlags_o,
    output logic [31:0]             cp0RdData_o
);

    exceptPkg::cp0View_t     storedView;
    exceptPkg::cp0View_t     curView;
    exceptPkg::exceptFlags_t flags;
    exceptPkg::trapCommit_t  commit;

    // **************************************************
    // cp0 state and forwarding half
    // **************************************************
    cp0Regs cp0Regs_inst (
        .clk_i        (clk_i),
        .rstN_i       (rstN_i),
        .wbCp0Wr_i    (wbCp0Wr_i),
        .hwInt_i      (hwInt_i),
        .commit_i     (commit),
        .rdAddr_i     (cp0RdAddr_i),
        .storedView_o (storedView),
        .rdData_o     (cp0RdData_o)
    );

    cp0Bypass cp0Bypass_inst (
        .storedView_i (storedView),
        .wbCp0Wr_i    (wbCp0Wr_i),
        .curView_o    (curView)
    );

    // **************************************************
    // flag half and resolver
    // **************************************************
    exceptCollect exceptCollect_inst (
        .instValid_i (instValid_i),
        .pc_i        (pc_i),
        .pipeFlags_i (pipeFlags_i),
        .flags_o     (flags)
    );

    exceptResolve exceptResolve_inst (
        .instValid_i  (instValid_i),
        .pc_i         (pc_i),
        .memAddr_i    (memAddr_i),
        .flags_i      (flags),
        .curView_i    (curView),
        .memWrType_i  (memWrType_i),
        .excFlags_o   (excFlags_o),
        .memWrType_o  (memWrType_o),
        .flush_o      (flush_o),
        .npcSel_o     (npcSel_o),
        .redirectPc_o (redirectPc_o),
        .commit_o     (commit)
    );

endmodule

// File: logic/exceptResolve.sv
`timescale 1ns/1ps

module exceptResolve (
    input  logic                    instValid_i,
    input  logic [31:0]             pc_i,
    input  logic [31:0]             memAddr_i,
    input  exceptPkg::exceptFlags_t flags_i,
    input  exceptPkg::cp0View_t     curView_i,
    input  exceptPkg::regsWrType_t  memWrType_i,
    output exceptPkg::exceptFlags_t excFlags_o,
    output exceptPkg::regsWrType_t  memWrType_o,
    output logic                    flush_o,
    output exceptPkg::npcSel_e      npcSel_o,
    output logic [31:0]             redirectPc_o,
    output exceptPkg::trapCommit_t  commit_o
);

    logic                    intPending;
    exceptPkg::exceptFlags_t allFlags;
    logic                    anyExc;

    // **************************************************
    // interrupt detection
    // **************************************************
    // pending & unmasked, not in exception level, IE on
    assign intPending = instValid_i
        && ((curView_i.cause[exceptPkg::CAUSE_IP_HI:exceptPkg::CAUSE_IP_LO]
             & curView_i.status[exceptPkg::STATUS_IM_HI:exceptPkg::STATUS_IM_LO]) != 8'h00)
        && !curView_i.status[exceptPkg::STATUS_EXL]
        && curView_i.status[exceptPkg::STATUS_IE];

    always_comb begin
        allFlags           = flags_i;
        allFlags.interrupt = intPending;
    end

    // **************************************************
    // priority select, highest first
    // **************************************************
    always_comb begin
        excFlags_o           = '0;
        commit_o             = '0;
        commit_o.epc         = pc_i;
        if (allFlags.interrupt) begin
            excFlags_o.interrupt = 1'b1;
            commit_o.excCode     = exceptPkg::EXC_INT;
        end else if (allFlags.fetchAddrErr) begin
            // bad fetch address is the pc itself
            excFlags_o.fetchAddrErr = 1'b1;
            commit_o.excCode        = exceptPkg::EXC_ADEL;
            commit_o.setBadVAddr    = 1'b1;
            commit_o.badVAddr       = pc_i;
        end else if (allFlags.reservedInstr) begin
            excFlags_o.reservedInstr = 1'b1;
            commit_o.excCode         = exceptPkg::EXC_RI;
        end else if (allFlags.syscall) begin
            excFlags_o.syscall = 1'b1;
            commit_o.excCode   = exceptPkg::EXC_SYS;
        end else if (allFlags.breakpoint) begin
            excFlags_o.breakpoint = 1'b1;
            commit_o.excCode      = exceptPkg::EXC_BP;
        end else if (allFlags.overflow) begin
            excFlags_o.overflow = 1'b1;
            commit_o.excCode    = exceptPkg::EXC_OV;
        end else if (allFlags.storeAddrErr) begin
            excFlags_o.storeAddrErr = 1'b1;
            commit_o.excCode        = exceptPkg::EXC_ADES;
            commit_o.setBadVAddr    = 1'b1;
            commit_o.badVAddr       = memAddr_i;
        end else if (allFlags.loadAddrErr) begin
            excFlags_o.loadAddrErr = 1'b1;
            commit_o.excCode       = exceptPkg::EXC_ADEL;
            commit_o.setBadVAddr   = 1'b1;
            commit_o.badVAddr      = memAddr_i;
        end else if (allFlags.eret) begin
            // lowest, only when nothing else fired
            excFlags_o.eret = 1'b1;
            commit_o.isEret = 1'b1;
        end
        commit_o.take = |excFlags_o;
    end

    assign anyExc = |excFlags_o;

    // **************************************************
    // flush, redirect, write suppression
    // **************************************************
    assign flush_o      = anyExc;
    assign memWrType_o  = anyExc ? '0 : memWrType_i;
    assign npcSel_o     = !anyExc         ? exceptPkg::NPC_NONE :
                          excFlags_o.eret ? exceptPkg::NPC_ERET : exceptPkg::NPC_TRAP;
    // eret returns through the forwarded epc
    assign redirectPc_o = excFlags_o.eret ? curView_i.epc : exceptPkg::TRAP_VECTOR;

endmodule

// File: logic/exceptCollect.sv
`timescale 1ns/1ps

module exceptCollect (
    input  logic                    instValid_i,
    input  logic [31:0]             pc_i,
    input  exceptPkg::exceptFlags_t pipeFlags_i,
    output exceptPkg::exceptFlags_t flags_o
);

    // fetch address must be word aligned
    logic pcMisaligned;

    assign pcMisaligned = (pc_i[1:0] != 2'b00);

    // **************************************************
    // flag gathering
    // **************************************************
    always_comb begin
        flags_o = '0;

        // bubble or stall, nothing is raised
        if (instValid_i) begin
            // interrupt comes from the resolver
            flags_o.interrupt     = 1'b0;
            // checked here, the pipeline bit is ignored
            flags_o.fetchAddrErr  = pcMisaligned;
            // decode / execute flags copied as is
            flags_o.reservedInstr = pipeFlags_i.reservedInstr;
            flags_o.syscall       = pipeFlags_i.syscall;
            flags_o.breakpoint    = pipeFlags_i.breakpoint;
            flags_o.overflow      = pipeFlags_i.overflow;
            flags_o.storeAddrErr  = pipeFlags_i.storeAddrErr;
            flags_o.loadAddrErr   = pipeFlags_i.loadAddrErr;
            flags_o.eret          = pipeFlags_i.eret;
        end
    end

endmodule

// File: logic/cp0Bypass.sv
`timescale 1ns/1ps

module cp0Bypass (
    input  exceptPkg::cp0View_t  storedView_i,
    input  exceptPkg::cp0Write_t wbCp0Wr_i,
    output exceptPkg::cp0View_t  curView_o
);

    logic statusHit;
    logic causeHit;
    logic epcHit;

    // **************************************************
    // writeback address match
    // **************************************************
    assign statusHit = wbCp0Wr_i.wr && (wbCp0Wr_i.addr == exceptPkg::CP0_STATUS);
    assign causeHit  = wbCp0Wr_i.wr && (wbCp0Wr_i.addr == exceptPkg::CP0_CAUSE);
    assign epcHit    = wbCp0Wr_i.wr && (wbCp0Wr_i.addr == exceptPkg::CP0_EPC);

    // **************************************************
    // forwarded values
    // **************************************************
    always_comb begin
        curView_o = storedView_i;

        // status is fully writable
        if (statusHit) begin
            curView_o.status = wbCp0Wr_i.data;
        end

        // masked merge, pending hw interrupts
        // and ExcCode stay visible
        if (causeHit) begin
            curView_o.cause = (storedView_i.cause & ~exceptPkg::CAUSE_WR_MASK)
                            | (wbCp0Wr_i.data & exceptPkg::CAUSE_WR_MASK);
        end

        // new epc goes straight to an eret in mem
        if (epcHit) begin
            curView_o.epc = wbCp0Wr_i.data;
        end
    end

endmodule

// File: logic/cp0Regs.sv
`timescale 1ns/1ps

module cp0Regs (
    input  logic                   clk_i,
    input  logic                   rstN_i,
    input  exceptPkg::cp0Write_t   wbCp0Wr_i,
    input  logic [5:0]             hwInt_i,
    input  exceptPkg::trapCommit_t commit_i,
    input  logic [4:0]             rdAddr_i,
    output exceptPkg::cp0View_t    storedView_o,
    output logic [31:0]            rdData_o
);

    logic [31:0] status;
    logic [31:0] cause;
    logic [31:0] epc;
    logic [31:0] badVAddr;

    // **************************************************
    // register update
    // **************************************************
    // later assignments win, so commit overrides the
    // writeback write on any field both of them touch
    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            status   <= exceptPkg::STATUS_RESET;
            cause    <= '0;
            epc      <= '0;
            badVAddr <= '0;
        end else begin
            // mtc0 from writeback
            if (wbCp0Wr_i.wr) begin
                case (wbCp0Wr_i.addr)
                    exceptPkg::CP0_STATUS: begin
                        status <= wbCp0Wr_i.data;
                    end
                    exceptPkg::CP0_CAUSE: begin
                        // only IP[1:0], WP, IV change
                        cause <= (cause & ~exceptPkg::CAUSE_WR_MASK)
                               | (wbCp0Wr_i.data & exceptPkg::CAUSE_WR_MASK);
                    end
                    exceptPkg::CP0_EPC: begin
                        epc <= wbCp0Wr_i.data;
                    end
                    // badvaddr is read-only
                    default: begin
                    end
                endcase
            end

            // hw interrupt lines sampled every cycle
            cause[exceptPkg::CAUSE_IP_HI:exceptPkg::CAUSE_HWIP_LO] <= hwInt_i;

            // trap / eret commit
            if (commit_i.take) begin
                if (commit_i.isEret) begin
                    // leave exception level
                    status[exceptPkg::STATUS_EXL] <= 1'b0;
                end else begin
                    status[exceptPkg::STATUS_EXL] <= 1'b1;
                    epc <= commit_i.epc;
                    cause[exceptPkg::CAUSE_EXC_HI:exceptPkg::CAUSE_EXC_LO] <= commit_i.excCode;
                    // address errors only
                    if (commit_i.setBadVAddr) begin
                        badVAddr <= commit_i.badVAddr;
                    end
                end
            end
        end
    end

    // stored state for the bypass
    assign storedView_o.status = status;
    assign storedView_o.cause  = cause;
    assign storedView_o.epc    = epc;

    // **************************************************
    // mfc0 read port
    // **************************************************
    always_comb begin
        case (rdAddr_i)
            exceptPkg::CP0_BADVADDR: rdData_o = badVAddr;
            exceptPkg::CP0_STATUS:   rdData_o = status;
            exceptPkg::CP0_CAUSE:    rdData_o = cause;
            exceptPkg::CP0_EPC:      rdData_o = epc;
            // unimplemented registers read as zero
            default:                 rdData_o = '0;
        endcase
    end

endmodule

// File: logic/exceptPkg.sv
package exceptPkg;

    // **************************************************
    // cp0 register addresses
    // **************************************************
    localparam logic [4:0] CP0_BADVADDR = 5'd8;
    localparam logic [4:0] CP0_STATUS   = 5'd12;
    localparam logic [4:0] CP0_CAUSE    = 5'd13;
    localparam logic [4:0] CP0_EPC      = 5'd14;

    // exception codes written into cause.ExcCode
    localparam logic [4:0] EXC_INT  = 5'd0;
    localparam logic [4:0] EXC_ADEL = 5'd4;
    localparam logic [4:0] EXC_ADES = 5'd5;
    localparam logic [4:0] EXC_SYS  = 5'd8;
    localparam logic [4:0] EXC_BP   = 5'd9;
    localparam logic [4:0] EXC_RI   = 5'd10;
    localparam logic [4:0] EXC_OV   = 5'd12;

    // general exception entry, BEV=1
    localparam logic [31:0] TRAP_VECTOR  = 32'hBFC0_0380;
    // BEV set, IE/EXL/IM clear
    localparam logic [31:0] STATUS_RESET = 32'h0040_0000;

    // status fields
    localparam int STATUS_IE    = 0;
    localparam int STATUS_EXL   = 1;
    localparam int STATUS_IM_LO = 8;
    localparam int STATUS_IM_HI = 15;

    // cause fields, hw interrupt lines land in IP[7:2]
    localparam int CAUSE_EXC_LO  = 2;
    localparam int CAUSE_EXC_HI  = 6;
    localparam int CAUSE_IP_LO   = 8;
    localparam int CAUSE_HWIP_LO = 10;
    localparam int CAUSE_IP_HI   = 15;
    // IP[1:0], WP, IV are the only software-writable bits
    localparam logic [31:0] CAUSE_WR_MASK = 32'h00C0_0300;

    // **************************************************
    // shared types
    // **************************************************
    // msb first, declaration order is also priority order
    typedef struct packed {
        logic interrupt;
        logic fetchAddrErr;
        logic reservedInstr;
        logic syscall;
        logic breakpoint;
        logic overflow;
        logic storeAddrErr;
        logic loadAddrErr;
        logic eret;
    } exceptFlags_t;

    // write enables carried with an instruction
    typedef struct packed {
        logic rfWr;
        logic cp0Wr;
        logic hiloWr;
    } regsWrType_t;

    // mtc0 write from writeback
    typedef struct packed {
        logic        wr;
        logic [4:0]  addr;
        logic [31:0] data;
    } cp0Write_t;

    typedef struct packed {
        logic [31:0] status;
        logic [31:0] cause;
        logic [31:0] epc;
    } cp0View_t;

    // trap or eret record applied to cp0 at the next edge
    typedef struct packed {
        logic        take;
        logic        isEret;
        logic [4:0]  excCode;
        logic        setBadVAddr;
        logic [31:0] epc;
        logic [31:0] badVAddr;
    } trapCommit_t;

    typedef enum logic [1:0] {
        NPC_NONE = 2'd0,
        NPC_TRAP = 2'd1,
        NPC_ERET = 2'd2
    } npcSel_e;

endpackage
